// ==== Makefile ====
TOP := tb_ctu_clock_tree

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f ctu_clock_tree.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f ctu_clock_tree.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | \
		grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

// ==== ctu_clock_tree.f ====
design/ctu_pkg.sv
design/ctu_reset_sequencer.sv
design/sync_repeater.sv
design/cluster_header.sv
design/cluster_status_collector.sv
design/ctu_clock_tree.sv
test/tb_clock_gen.sv
test/ctu_clock_tree_chk.sv
test/tb_ctu_clock_tree.sv

// ==== design/cluster_header.sv ====
`timescale 1ns/1ps

// Per-cluster header.
// The cluster clock enable is brought into the cluster through a plain
// two-flop pair, and stands in for the gated cluster clock. The global reset
// and debug-init go through scannable repeaters that form this header's
// piece of the scan chain
module cluster_header (
   input  logic gclk,
   input  logic rst_n,
   input  logic cluster_cken,
   input  logic grst_l,
   input  logic gdbginit_l,
   input  logic si,
   input  logic se,
   output logic clk_en,
   output logic cluster_grst_l,
   output logic dbginit_l,
   output logic so
);

   // Master and slave of the clock-enable synchronizer
   logic cken_master;
   logic cken_slave;

   // Scan link between the reset repeater and the debug-init repeater
   logic rst_sync_so;

   // The clock-enable pair is not on the scan chain.
   // cluster_cken shows up on clk_en two gclk edges later
   always_ff @(posedge gclk) begin
      if (!rst_n) begin
         cken_master <= 1'b0;
         cken_slave  <= 1'b0;
      end else begin
         cken_master <= cluster_cken;
         cken_slave  <= cken_master;
      end
   end

   assign clk_en = cken_slave;

   // The reset repeater is first on the chain and takes the header's si
   sync_repeater rst_repeater (
      .gclk     (gclk),
      .rst_n    (rst_n),
      .async_in (grst_l),
      .si       (si),
      .se       (se),
      .sync_out (cluster_grst_l),
      .so       (rst_sync_so)
   );

   // The debug-init repeater is second on the chain.
   // Its scan output leaves the header
   sync_repeater dbginit_repeater (
      .gclk     (gclk),
      .rst_n    (rst_n),
      .async_in (gdbginit_l),
      .si       (rst_sync_so),
      .se       (se),
      .sync_out (dbginit_l),
      .so       (so)
   );

endmodule

// ==== design/cluster_status_collector.sv ====
`timescale 1ns/1ps

// Status collector for the cluster headers.
// It reduces the per-cluster outputs to a few registered summary signals,
// one cycle behind the headers
module cluster_status_collector #(
   parameter int NUM_CLUSTERS = ctu_pkg::num_clusters_default
) (
   input  logic                                gclk,
   input  logic                                rst_n,
   input  logic [NUM_CLUSTERS-1:0]             clk_en,
   input  logic [NUM_CLUSTERS-1:0]             grst_l,
   input  logic [NUM_CLUSTERS-1:0]             dbginit_l,
   output logic                                all_ready,
   output logic                                dbg_active,
   output logic [$clog2(NUM_CLUSTERS+1)-1:0]   enabled_count
);

   // Width of the enabled-cluster count
   localparam int cnt_w = $clog2(NUM_CLUSTERS + 1);

   // Number of clusters whose enable is high this cycle
   logic [cnt_w-1:0] enabled_sum;

   // Any cluster currently sees debug-init asserted
   logic any_dbginit;

   // Population count of the enables
   always_comb begin
      enabled_sum = '0;
      for (int i = 0; i < NUM_CLUSTERS; i++) begin
         enabled_sum = enabled_sum + cnt_w'(clk_en[i]);
      end
   end

   assign any_dbginit = ~&dbginit_l;

   // The repeaters clear to 0 in reset, which looks like debug-init
   // asserted everywhere. Qualifying with all_ready hides that, since
   // all_ready only rises once every cluster reset has been released
   always_ff @(posedge gclk) begin
      if (!rst_n) begin
         all_ready     <= 1'b0;
         dbg_active    <= 1'b0;
         enabled_count <= '0;
      end else begin
         all_ready     <= &grst_l;
         dbg_active    <= all_ready & any_dbginit;
         enabled_count <= enabled_sum;
      end
   end

endmodule

// ==== design/ctu_clock_tree.sv ====
`timescale 1ns/1ps

// Top of the clock and reset control model.
// One sequencer drives the global reset and debug-init into NUM_CLUSTERS
// identical headers, whose repeaters form a single scan chain from si to so.
// A collector sums up the header outputs
module ctu_clock_tree #(
   parameter int NUM_CLUSTERS = ctu_pkg::num_clusters_default,
   parameter int RESET_HOLD   = ctu_pkg::reset_hold_default,
   parameter int DBG_HOLD     = ctu_pkg::dbg_hold_default
) (
   input  logic                                gclk,
   input  logic                                rst_n,
   input  logic                                dbg_req,
   input  logic                                si,
   input  logic                                se,
   input  logic [NUM_CLUSTERS-1:0]             cluster_cken,
   output logic [NUM_CLUSTERS-1:0]             cluster_clk_en,
   output logic [NUM_CLUSTERS-1:0]             cluster_grst_l,
   output logic [NUM_CLUSTERS-1:0]             dbginit_l,
   output logic                                all_ready,
   output logic                                dbg_active,
   output logic [$clog2(NUM_CLUSTERS+1)-1:0]   enabled_count,
   output logic                                so
);

   // Global controls from the sequencer, fanned out to every header
   logic grst_l;
   logic gdbginit_l;

   // Scan links, entry k feeds header k and entry k+1 is its output
   logic [NUM_CLUSTERS:0] scan_link;

   ctu_reset_sequencer #(
      .RESET_HOLD (RESET_HOLD),
      .DBG_HOLD   (DBG_HOLD)
   ) u_ctu_reset_sequencer (
      .gclk       (gclk),
      .rst_n      (rst_n),
      .dbg_req    (dbg_req),
      .grst_l     (grst_l),
      .gdbginit_l (gdbginit_l)
   );

   assign scan_link[0] = si;

   // Header 0 sits at the head of the scan chain
   for (genvar k = 0; k < NUM_CLUSTERS; k++) begin : g_header
      cluster_header u_cluster_header (
         .gclk           (gclk),
         .rst_n          (rst_n),
         .cluster_cken   (cluster_cken[k]),
         .grst_l         (grst_l),
         .gdbginit_l     (gdbginit_l),
         .si             (scan_link[k]),
         .se             (se),
         .clk_en         (cluster_clk_en[k]),
         .cluster_grst_l (cluster_grst_l[k]),
         .dbginit_l      (dbginit_l[k]),
         .so             (scan_link[k+1])
      );
   end

   assign so = scan_link[NUM_CLUSTERS];

   cluster_status_collector #(
      .NUM_CLUSTERS (NUM_CLUSTERS)
   ) u_cluster_status_collector (
      .gclk          (gclk),
      .rst_n         (rst_n),
      .clk_en        (cluster_clk_en),
      .grst_l        (cluster_grst_l),
      .dbginit_l     (dbginit_l),
      .all_ready     (all_ready),
      .dbg_active    (dbg_active),
      .enabled_count (enabled_count)
   );

endmodule

// ==== design/ctu_pkg.sv ====
// Shared constants for the clock and reset control unit and its cluster headers
package ctu_pkg;

   // Number of cluster headers hung off the control unit by default
   localparam int num_clusters_default = 4;

   // Cycles the global reset is held low once rst_n has been released.
   // The counter in the sequencer runs on gclk, so this is a gclk count
   localparam int reset_hold_default = 8;

   // Width of the debug-init pulse in gclk cycles
   localparam int dbg_hold_default = 5;

   // Depth of each synchronizer in a cluster header.
   // The scan segment length of every header is derived from this value,
   // so changing it also changes the scan chain length of the whole tree
   localparam int sync_stages = 2;

   // Scan flops per cluster header.
   // Each header carries two repeaters (reset and debug-init), and only those
   // two are on the chain; the clock-enable pair is left off the scan path
   localparam int scan_per_cluster = 2 * sync_stages;

endpackage

// ==== design/ctu_reset_sequencer.sv ====
`timescale 1ns/1ps

// Global reset and debug-init sequencer of the control unit.
// After rst_n is released, the global reset grst_l is held low for a fixed
// number of cycles and then raised for good. Once the tree is out of reset,
// a one-cycle dbg_req starts a debug-init pulse on gdbginit_l with a fixed
// width. A request that arrives while a pulse is running is dropped
module ctu_reset_sequencer #(
   parameter int RESET_HOLD = ctu_pkg::reset_hold_default,
   parameter int DBG_HOLD   = ctu_pkg::dbg_hold_default
) (
   input  logic gclk,
   input  logic rst_n,
   input  logic dbg_req,
   output logic grst_l,
   output logic gdbginit_l
);

   // Counter widths are sized so that the hold value itself fits
   localparam int rst_cnt_w = $clog2(RESET_HOLD + 1);
   localparam int dbg_cnt_w = $clog2(DBG_HOLD + 1);

   // Terminal values of the two counters
   localparam logic [rst_cnt_w-1:0] rst_last = rst_cnt_w'(RESET_HOLD - 1);
   localparam logic [dbg_cnt_w-1:0] dbg_last = dbg_cnt_w'(DBG_HOLD - 1);

   // Reset hold counter that counts the edges with rst_n high
   logic [rst_cnt_w-1:0] rst_cnt;

   // Remaining cycles of the running debug-init pulse
   logic [dbg_cnt_w-1:0] dbg_cnt;

   // A request is only taken when the tree is out of reset and no pulse runs
   logic dbg_accept;

   // The counter advances on every edge where rst_n is sampled high.
   // On the RESET_HOLD-th such edge the global reset is released, and the
   // counter then saturates, so grst_l stays high until the next rst_n
   always_ff @(posedge gclk) begin
      if (!rst_n) begin
         rst_cnt <= '0;
         grst_l  <= 1'b0;
      end else if (!grst_l) begin
         if (rst_cnt == rst_last) begin
            grst_l <= 1'b1;
         end else begin
            rst_cnt <= rst_cnt + 1'b1;
         end
      end
   end

   // The sequencer is idle while gdbginit_l is high
   assign dbg_accept = dbg_req & grst_l & gdbginit_l;

   // The pulse goes low on the edge that samples the request.
   // The counter is loaded with DBG_HOLD-1 and runs down to zero, which
   // keeps gdbginit_l low for exactly DBG_HOLD cycles
   always_ff @(posedge gclk) begin
      if (!rst_n) begin
         // Debug-init is active low and sits high through reset
         gdbginit_l <= 1'b1;
         dbg_cnt    <= '0;
      end else if (!gdbginit_l) begin
         // A request that arrives while the pulse runs is dropped
         if (dbg_cnt == '0) begin
            gdbginit_l <= 1'b1;
         end else begin
            dbg_cnt <= dbg_cnt - 1'b1;
         end
      end else if (dbg_accept) begin
         gdbginit_l <= 1'b0;
         dbg_cnt    <= dbg_last;
      end
   end

endmodule

// ==== design/sync_repeater.sv ====
`timescale 1ns/1ps

// Flop-based synchronizer that repeats a global control level into a
// cluster. The first stage doubles as the scan input mux, so the chain of
// stages is also a piece of the scan chain when se is high
module sync_repeater (
   input  logic gclk,
   input  logic rst_n,
   input  logic async_in,
   input  logic si,
   input  logic se,
   output logic sync_out,
   output logic so
);

   import ctu_pkg::*;

   // Synchronizer stages, index 0 is the capture flop
   logic [sync_stages-1:0] stage;

   // Value loaded into the capture flop
   logic stage_d;

   // In scan mode the capture flop takes si instead of the functional input
   assign stage_d = se ? si : async_in;

   // The later stages shift the earlier ones in both modes.
   // All stages clear to 0, so a repeater reads as asserted-low in reset
   always_ff @(posedge gclk) begin
      if (!rst_n) begin
         stage <= '0;
      end else begin
         stage <= {stage[sync_stages-2:0], stage_d};
      end
   end

   // The functional output and the scan output share the last stage
   assign sync_out = stage[sync_stages-1];
   assign so       = stage[sync_stages-1];

endmodule

// ==== test/ctu_clock_tree_chk.sv ====
`timescale 1ns/1ps

// Port-level checks for ctu_clock_tree, attached by bind.
// Expected values come from the timing rules of the tree, tracked by a few
// small counters that run on gclk next to the DUT
module ctu_clock_tree_chk #(
   parameter int NUM_CLUSTERS = ctu_pkg::num_clusters_default,
   parameter int RESET_HOLD   = ctu_pkg::reset_hold_default,
   parameter int DBG_HOLD     = ctu_pkg::dbg_hold_default
) (
   input  logic                                gclk,
   input  logic                                rst_n,
   input  logic                                dbg_req,
   input  logic                                si,
   input  logic                                se,
   input  logic [NUM_CLUSTERS-1:0]             cluster_cken,
   input  logic [NUM_CLUSTERS-1:0]             cluster_clk_en,
   input  logic [NUM_CLUSTERS-1:0]             cluster_grst_l,
   input  logic [NUM_CLUSTERS-1:0]             dbginit_l,
   input  logic                                all_ready,
   input  logic                                dbg_active,
   input  logic [$clog2(NUM_CLUSTERS+1)-1:0]   enabled_count,
   input  logic                                so
);

   import ctu_pkg::*;

   localparam int cnt_w     = $clog2(NUM_CLUSTERS + 1);
   localparam int chain_len = scan_per_cluster * NUM_CLUSTERS;
   localparam int run_max   = 1000000;

   // Edges with rst_n high since the last reset
   int since_rst;

   // Consecutive edges with se high, the scan chain is full once this
   // reaches the chain length
   int se_run;

   // Scan was used since the last reset, so the repeaters hold scan data
   logic scan_seen;

   // Accepted debug requests, bit j holds the one taken j+1 edges ago
   logic [DBG_HOLD+1:0] dbg_hist;
   logic dbg_accept;
   logic dbg_low_exp;
   logic [NUM_CLUSTERS-1:0] dbginit_exp;

   // First edge has no history, so the reset check waits one edge
   logic seen_edge = 1'b0;
   logic rst_low_q = 1'b0;

   // Failures and hit counts, read by the testbench at the end of the run
   int fail_cnt      = 0;
   int reach_reset   = 0;
   int reach_release = 0;
   int reach_cken    = 0;
   int reach_count   = 0;
   int reach_dbg     = 0;
   int reach_ignored = 0;
   int reach_scan    = 0;

   // The sequencer takes a request once grst_l is up and no pulse runs.
   // grst_l rises on the RESET_HOLD-th edge, so it is seen one edge later
   assign dbg_accept  = dbg_req && (since_rst >= RESET_HOLD) && !(|dbg_hist[DBG_HOLD-1:0]);
   // Low at the clusters 3 through DBG_HOLD+2 edges after the request
   assign dbg_low_exp = |dbg_hist[DBG_HOLD+1:2];
   assign dbginit_exp = {NUM_CLUSTERS{(since_rst >= 2) && !dbg_low_exp}};

   always_ff @(posedge gclk) begin
      if (!rst_n) begin
         since_rst <= 0;
         se_run    <= 0;
         scan_seen <= 1'b0;
         dbg_hist  <= '0;
      end else begin
         if (since_rst < run_max) begin
            since_rst <= since_rst + 1;
         end
         if (!se) begin
            se_run <= 0;
         end else if (se_run < run_max) begin
            se_run <= se_run + 1;
         end
         if (se) begin
            scan_seen <= 1'b1;
         end
         dbg_hist <= {dbg_hist[DBG_HOLD:0], dbg_accept};
      end
   end

   // Hit counts survive a reset, so both reset releases are counted
   always @(posedge gclk) begin
      seen_edge <= 1'b1;
      rst_low_q <= !rst_n;
      if (seen_edge && rst_low_q) begin
         reach_reset <= reach_reset + 1;
      end
      if (rst_n && !scan_seen && since_rst == RESET_HOLD + 3) begin
         reach_release <= reach_release + 1;
      end
      if (rst_n && since_rst >= 2 && cluster_clk_en != '0) begin
         reach_cken <= reach_cken + 1;
      end
      if (rst_n && since_rst >= 1 && enabled_count != '0) begin
         reach_count <= reach_count + 1;
      end
      if (rst_n && !scan_seen && dbg_low_exp) begin
         reach_dbg <= reach_dbg + 1;
      end
      if (rst_n && dbg_req && (|dbg_hist[DBG_HOLD-1:0])) begin
         reach_ignored <= reach_ignored + 1;
      end
      if (rst_n && se_run >= chain_len) begin
         reach_scan <= reach_scan + 1;
      end
   end

   // Every flop clears to 0, which also reads as debug-init asserted
   a_reset_values: assert property (@(posedge gclk)
      seen_edge && rst_low_q |-> cluster_clk_en == '0 && cluster_grst_l == '0
         && dbginit_l == '0 && !all_ready && !dbg_active && enabled_count == '0)
      else begin
         $error("[ERROR] %0t: outputs not at their reset values", $time);
         fail_cnt = fail_cnt + 1;
      end

   // Cluster resets lift one edge before all_ready
   a_grst_release: assert property (@(posedge gclk) disable iff (!rst_n || scan_seen)
      cluster_grst_l == {NUM_CLUSTERS{since_rst >= RESET_HOLD + 2}})
      else begin
         $error("[ERROR] %0t: cluster_grst_l wrong after reset release", $time);
         fail_cnt = fail_cnt + 1;
      end

   a_ready_release: assert property (@(posedge gclk) disable iff (!rst_n || scan_seen)
      all_ready == (since_rst >= RESET_HOLD + 3))
      else begin
         $error("[ERROR] %0t: all_ready wrong after reset release", $time);
         fail_cnt = fail_cnt + 1;
      end

   a_clk_en_delay: assert property (@(posedge gclk) disable iff (!rst_n)
      since_rst >= 2 |-> cluster_clk_en == $past(cluster_cken, 2))
      else begin
         $error("[ERROR] %0t: cluster_clk_en does not follow cluster_cken", $time);
         fail_cnt = fail_cnt + 1;
      end

   a_enabled_count: assert property (@(posedge gclk) disable iff (!rst_n)
      since_rst >= 1 |-> enabled_count == cnt_w'($countones($past(cluster_clk_en))))
      else begin
         $error("[ERROR] %0t: enabled_count is not the count of enables", $time);
         fail_cnt = fail_cnt + 1;
      end

   // A second request inside a pulse must not stretch it
   a_dbginit_pulse: assert property (@(posedge gclk) disable iff (!rst_n || scan_seen)
      dbginit_l == dbginit_exp)
      else begin
         $error("[ERROR] %0t: dbginit_l pulse has the wrong start or width", $time);
         fail_cnt = fail_cnt + 1;
      end

   a_dbg_active: assert property (@(posedge gclk) disable iff (!rst_n || scan_seen)
      dbg_active == ((since_rst >= RESET_HOLD + 4) && $past(dbg_low_exp)))
      else begin
         $error("[ERROR] %0t: dbg_active does not follow dbginit_l", $time);
         fail_cnt = fail_cnt + 1;
      end

   a_scan_path: assert property (@(posedge gclk) disable iff (!rst_n)
      se_run >= chain_len |-> so == $past(si, chain_len))
      else begin
         $error("[ERROR] %0t: so does not match si after the chain delay", $time);
         fail_cnt = fail_cnt + 1;
      end

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

// Clock and reset source for the testbench.
// gclk toggles every 2 ns for a 4 ns period. rst_n is held low for
// RESET_CYCLES rising edges at start-up, and again after every edge that
// samples reset_req high
module tb_clock_gen #(
   parameter int RESET_CYCLES = 4
) (
   input  logic reset_req,
   output logic gclk,
   output logic rst_n
);

   // Edges still to go with rst_n low
   int hold_left = RESET_CYCLES;

   initial begin
      gclk  = 1'b0;
      rst_n = 1'b0;
   end

   always #2 gclk = ~gclk;

   // rst_n changes only on the rising edge, like every other DUT input
   always @(posedge gclk) begin
      if (reset_req) begin
         rst_n     <= 1'b0;
         hold_left <= RESET_CYCLES;
      end else if (hold_left != 0) begin
         hold_left <= hold_left - 1;
         rst_n     <= (hold_left == 1);
      end
   end

endmodule

// ==== test/tb_ctu_clock_tree.sv ====
`timescale 1ns/1ps

// Testbench for ctu_clock_tree.
// The bound checker does the checking. This module only walks the DUT
// through reset, random enables, debug-init pulses and a scan shift, then
// collects the checker's counts for the closing line
module tb_ctu_clock_tree;

   import ctu_pkg::*;

   localparam int n_clusters      = num_clusters_default;
   localparam int reset_hold      = reset_hold_default;
   localparam int dbg_hold        = dbg_hold_default;
   localparam int chain_len       = scan_per_cluster * n_clusters;
   localparam int watchdog_cycles = reset_hold + 40 * n_clusters + 400;

   logic gclk;
   logic rst_n;
   logic reset_req;
   logic dbg_req;
   logic si;
   logic se;
   logic [n_clusters-1:0] cluster_cken;
   logic [n_clusters-1:0] cluster_clk_en;
   logic [n_clusters-1:0] cluster_grst_l;
   logic [n_clusters-1:0] dbginit_l;
   logic all_ready;
   logic dbg_active;
   logic [$clog2(n_clusters+1)-1:0] enabled_count;
   logic so;

   int seed;
   // Checks that the stimulus never got to
   int missed = 0;

   tb_clock_gen #(
      .RESET_CYCLES (4)
   ) u_tb_clock_gen (
      .reset_req (reset_req),
      .gclk      (gclk),
      .rst_n     (rst_n)
   );

   ctu_clock_tree #(
      .NUM_CLUSTERS (n_clusters),
      .RESET_HOLD   (reset_hold),
      .DBG_HOLD     (dbg_hold)
   ) u_ctu_clock_tree (
      .gclk           (gclk),
      .rst_n          (rst_n),
      .dbg_req        (dbg_req),
      .si             (si),
      .se             (se),
      .cluster_cken   (cluster_cken),
      .cluster_clk_en (cluster_clk_en),
      .cluster_grst_l (cluster_grst_l),
      .dbginit_l      (dbginit_l),
      .all_ready      (all_ready),
      .dbg_active     (dbg_active),
      .enabled_count  (enabled_count),
      .so             (so)
   );

   // Names in the port list resolve inside ctu_clock_tree
   bind ctu_clock_tree ctu_clock_tree_chk #(
      .NUM_CLUSTERS (NUM_CLUSTERS),
      .RESET_HOLD   (RESET_HOLD),
      .DBG_HOLD     (DBG_HOLD)
   ) u_ctu_clock_tree_chk (
      .gclk           (gclk),
      .rst_n          (rst_n),
      .dbg_req        (dbg_req),
      .si             (si),
      .se             (se),
      .cluster_cken   (cluster_cken),
      .cluster_clk_en (cluster_clk_en),
      .cluster_grst_l (cluster_grst_l),
      .dbginit_l      (dbginit_l),
      .all_ready      (all_ready),
      .dbg_active     (dbg_active),
      .enabled_count  (enabled_count),
      .so             (so)
   );

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge gclk);
   endtask

   // Outputs are read on the falling edge, away from the flop updates
   task automatic wait_ready();
      @(negedge gclk);
      while (!rst_n || !all_ready) begin
         @(negedge gclk);
      end
   endtask

   task automatic pulse_dbg_req();
      @(posedge gclk);
      dbg_req <= 1'b1;
      @(posedge gclk);
      dbg_req <= 1'b0;
   endtask

   task automatic drive_random_cken(input int n);
      repeat (n) begin
         @(posedge gclk);
         cluster_cken <= n_clusters'($random(seed));
      end
   endtask

   task automatic shift_scan(input int n);
      repeat (n) begin
         @(posedge gclk);
         se <= 1'b1;
         si <= 1'($random(seed));
      end
   endtask

   task automatic check_reached(input string name, input int count, input int need);
      if (count < need) begin
         $display("Check never reached by the stimulus: %s", name);
         missed = missed + 1;
      end
   endtask

   task automatic finish_run(input bit timed_out);
      int fails;
      int reached;
      int errors;
      fails   = u_ctu_clock_tree.u_ctu_clock_tree_chk.fail_cnt;
      reached = u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_reset
              + u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_release
              + u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_cken
              + u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_count
              + u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_dbg
              + u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_ignored
              + u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_scan;
      errors  = fails + missed + (timed_out ? 1 : 0);
      $display("errors %0d, assertion failures %0d, checks missed %0d, assertions reached %0d",
               errors, fails, missed, reached);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   endtask

   initial begin
      seed         = 32'h41566758;
      reset_req    = 1'b0;
      dbg_req      = 1'b0;
      si           = 1'b0;
      se           = 1'b0;
      cluster_cken = '0;

      wait_ready();
      wait_cycles(3);
      drive_random_cken(40);

      // One clean pulse, then a second request 3 edges into a pulse
      pulse_dbg_req();
      wait_cycles(dbg_hold + 6);
      pulse_dbg_req();
      wait_cycles(2);
      pulse_dbg_req();
      wait_cycles(dbg_hold + 6);

      // Fill the chain and keep shifting so the delayed bits come out on so
      shift_scan(chain_len + 24);
      @(posedge gclk);
      se        <= 1'b0;
      reset_req <= 1'b1;
      @(posedge gclk);
      reset_req <= 1'b0;
      wait_ready();
      wait_cycles(4);

      check_reached("reset values", u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_reset, 2);
      check_reached("reset release", u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_release, 2);
      check_reached("clock enable delay", u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_cken, 1);
      check_reached("enabled count", u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_count, 1);
      check_reached("debug-init pulse", u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_dbg, 1);
      check_reached("ignored request", u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_ignored, 1);
      check_reached("scan path", u_ctu_clock_tree.u_ctu_clock_tree_chk.reach_scan, 1);
      finish_run(1'b0);
   end

   // Sized from the cluster count, well above the length of the stimulus
   initial begin
      repeat (watchdog_cycles) @(posedge gclk);
      $display("Timeout: the run did not end within %0d cycles", watchdog_cycles);
      finish_run(1'b1);
   end

endmodule
